/* rtl/rf_pkg.sv */
// Shared types for the execute slice
// Struct fields are sized from the default widths below.
// A top level with other widths must stay within these fields.
// Mask bit 0 is never used because register 0 is hardwired.

package rf_pkg;

  // ------------------------------
  // Default widths
  // ------------------------------
  localparam int unsigned ADDR_WIDTH_DEF = 5;
  localparam int unsigned DATA_WIDTH_DEF = 32;

  // One register word
  typedef logic [DATA_WIDTH_DEF-1:0] rf_data_t;
  // Register index
  typedef logic [ADDR_WIDTH_DEF-1:0] rf_addr_t;
  // One protect bit per register
  typedef logic [2**ADDR_WIDTH_DEF-1:0] rf_mask_t;

  // ------------------------------
  // ALU operation codes
  // ------------------------------
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLL = 3'd5;
  localparam alu_op_t ALU_SRL = 3'd6;
  // Signed compare
  localparam alu_op_t ALU_SLT = 3'd7;

  // ------------------------------
  // Port bundles
  // ------------------------------
  // Operation strobe payload, 18 bits
  typedef struct packed {
    alu_op_t  op;
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_addr_t rd;
  } rf_op_t;

  // Register file write port
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
  } rf_wr_t;

  // sel 0 writes the mask, sel 1 writes the test register
  typedef struct packed {
    logic     sel;
    rf_data_t data;
  } cfg_wr_t;

  // Result returned one cycle after the operation
  typedef struct packed {
    rf_data_t data;
    logic     blocked;
  } rf_res_t;

endpackage

/* rtl/rf_clock_gate.sv */
// Behavioral clock gate, latch plus AND
// Swap for the library ICG cell in synthesis.
// Enable must be stable before the rising edge of clk_i.

`timescale 1ns/1ps

module rf_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // Enable as seen at the last rising edge
  logic en_latched;

  // Transparent while the clock is low so enable
  // changes in the high phase cannot glitch clk_o
  always_latch
  begin
    if (!clk_i)
    begin
      // Test enable forces the gate open
      en_latched <= en_i | test_en_i;
    end
  end

  // Gated clock
  assign clk_o = clk_i & en_latched;

endmodule

/* rtl/rf_latch_regfile.sv */
// Latch register file, two read ports and one write port
// Word 0 reads as zero and is never written.
// Write data is captured at the edge and loaded in the high phase after it.
// Test enable only opens the global gate; word gates follow the decode.
// Contents are undefined until written.

`timescale 1ns/1ps

module rf_latch_regfile #(
  parameter int unsigned ADDR_WIDTH = 5,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  test_en_i,
  // Read port A
  input  logic [ADDR_WIDTH-1:0] raddr_a_i,
  output logic [DATA_WIDTH-1:0] rdata_a_o,
  // Read port B
  input  logic [ADDR_WIDTH-1:0] raddr_b_i,
  output logic [DATA_WIDTH-1:0] rdata_b_o,
  // Write port
  input  rf_pkg::rf_wr_t        wr_i
);

  localparam int unsigned NUM_WORDS = 2**ADDR_WIDTH;

  // Storage, word 0 is constant
  logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

  // Gated clocks
  logic                  clk_global;
  logic [NUM_WORDS-1:1]  mem_clocks;

  // Write decode and captured data
  logic [NUM_WORDS-1:1]  waddr_onehot;
  logic [DATA_WIDTH-1:0] wdata_q;

  // ------------------------------
  // Read
  // ------------------------------
  // Plain mux over the latch outputs
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

  // ------------------------------
  // Write data capture
  // ------------------------------
  // Global gate runs only on write cycles, or always in test mode
  rf_clock_gate u_cg_global (
    .clk_i     (clk_i),
    .en_i      (wr_i.we),
    .test_en_i (test_en_i),
    .clk_o     (clk_global)
  );

  // Held in test mode when no write is requested
  always_ff @(posedge clk_global or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wdata_q <= '0;
    end
    else if (wr_i.we)
    begin
      wdata_q <= wr_i.wdata[DATA_WIDTH-1:0];
    end
  end

  // ------------------------------
  // Write address decode
  // ------------------------------
  always_comb
  begin
    for (int unsigned i = 1; i < NUM_WORDS; i++)
    begin
      waddr_onehot[i] = wr_i.we && (wr_i.waddr[ADDR_WIDTH-1:0] == ADDR_WIDTH'(i));
    end
  end

  // ------------------------------
  // Per-word gates
  // ------------------------------
  // No test override here, or test mode would overwrite
  // every word with the captured data
  for (genvar x = 1; x < NUM_WORDS; x++)
  begin : g_word_cg
    rf_clock_gate u_cg_word (
      .clk_i     (clk_global),
      .en_i      (waddr_onehot[x]),
      .test_en_i (1'b0),
      .clk_o     (mem_clocks[x])
    );
  end

  // ------------------------------
  // Word latches
  // ------------------------------
  // Each word is transparent while its gated clock is high
  always_latch
  begin
    mem[0] = '0;
    for (int unsigned k = 1; k < NUM_WORDS; k++)
    begin
      if (mem_clocks[k])
      begin
        mem[k] = wdata_q;
      end
    end
  end

endmodule

/* rtl/rf_protect_regs.sv */
// Configuration registers for the execute slice
// A strobe writes the mask (sel 0) or the test bit (sel 1).
// New values apply to operations from the next edge on.

`timescale 1ns/1ps

module rf_protect_regs (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Configuration strobe
  input  logic            cfg_valid_i,
  input  rf_pkg::cfg_wr_t cfg_i,
  // Held configuration
  output rf_pkg::rf_mask_t prot_mask_o,
  output logic            test_en_o
);

  import rf_pkg::*;

  // Register select values
  localparam logic SEL_MASK = 1'b0;
  localparam logic SEL_TEST = 1'b1;

  rf_mask_t prot_mask_q;
  logic     test_en_q;

  // Strobe decode
  logic     mask_wr;
  logic     test_wr;

  assign mask_wr = cfg_valid_i && (cfg_i.sel == SEL_MASK);
  assign test_wr = cfg_valid_i && (cfg_i.sel == SEL_TEST);

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      // Nothing protected, gates follow their enables
      prot_mask_q <= '0;
      test_en_q   <= 1'b0;
    end
    else
    begin
      if (mask_wr)
      begin
        // Bit 0 kept clear, register 0 is never written
        prot_mask_q <= {cfg_i.data[$bits(rf_mask_t)-1:1], 1'b0};
      end
      if (test_wr)
      begin
        // Only bit 0 is implemented
        test_en_q <= cfg_i.data[0];
      end
    end
  end

  assign prot_mask_o = prot_mask_q;
  assign test_en_o   = test_en_q;

endmodule

/* rtl/rf_alu.sv */
// Combinational integer ALU
// Shifts use the low five bits of b.
// SLT compares as signed and returns 0 or 1.

`timescale 1ns/1ps

module rf_alu (
  input  rf_pkg::alu_op_t  op_i,
  input  rf_pkg::rf_data_t a_i,
  input  rf_pkg::rf_data_t b_i,
  output rf_pkg::rf_data_t res_o
);

  import rf_pkg::*;

  // Shift amount
  logic [4:0] shamt;
  // Signed less-than flag
  logic       lt_signed;

  assign shamt     = b_i[4:0];
  assign lt_signed = $signed(a_i) < $signed(b_i);

  // ------------------------------
  // Operation select
  // ------------------------------
  always_comb
  begin
    unique case (op_i)
      ALU_ADD:
      begin
        res_o = a_i + b_i;
      end
      ALU_SUB:
      begin
        res_o = a_i - b_i;
      end
      ALU_AND:
      begin
        res_o = a_i & b_i;
      end
      ALU_OR:
      begin
        res_o = a_i | b_i;
      end
      ALU_XOR:
      begin
        res_o = a_i ^ b_i;
      end
      // Logical shifts, zero fill
      ALU_SLL:
      begin
        res_o = a_i << shamt;
      end
      ALU_SRL:
      begin
        res_o = a_i >> shamt;
      end
      ALU_SLT:
      begin
        res_o = rf_data_t'(lt_signed);
      end
      default:
      begin
        res_o = '0;
      end
    endcase
  end

endmodule

/* rtl/rf_issue_ctrl.sv */
// Operation issue and result stage
// One operation per cycle, no back-pressure.
// Write goes out in the operation cycle, result follows one cycle later.
// Writes to rd 0 are dropped silently, protected rd sets blocked.

`timescale 1ns/1ps

module rf_issue_ctrl #(
  parameter int unsigned ADDR_WIDTH = 5,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Operation strobe
  input  logic                  op_valid_i,
  input  rf_pkg::rf_op_t        op_i,
  input  rf_pkg::rf_mask_t      prot_mask_i,
  // Register file reads
  output logic [ADDR_WIDTH-1:0] raddr_a_o,
  output logic [ADDR_WIDTH-1:0] raddr_b_o,
  input  logic [DATA_WIDTH-1:0] rdata_a_i,
  input  logic [DATA_WIDTH-1:0] rdata_b_i,
  // ALU
  output rf_pkg::alu_op_t       alu_op_o,
  output rf_pkg::rf_data_t      alu_a_o,
  output rf_pkg::rf_data_t      alu_b_o,
  input  rf_pkg::rf_data_t      alu_res_i,
  // Register file write
  output rf_pkg::rf_wr_t        wr_o,
  // Result
  output logic                  res_valid_o,
  output rf_pkg::rf_res_t       res_o
);

  import rf_pkg::*;

  logic     rd_nonzero;
  logic     rd_prot;
  logic     blocked_d;

  // Result stage
  logic     res_valid_q;
  logic     blocked_q;
  rf_data_t res_data_q;

  // ------------------------------
  // Operand routing
  // ------------------------------
  assign raddr_a_o = op_i.rs1[ADDR_WIDTH-1:0];
  assign raddr_b_o = op_i.rs2[ADDR_WIDTH-1:0];
  assign alu_op_o  = op_i.op;
  assign alu_a_o   = rdata_a_i;
  assign alu_b_o   = rdata_b_i;

  // ------------------------------
  // Write request and protection
  // ------------------------------
  assign rd_nonzero = (op_i.rd != '0);
  assign rd_prot    = prot_mask_i[op_i.rd];

  // Only unprotected nonzero destinations are written
  assign wr_o.we    = op_valid_i && rd_nonzero && !rd_prot;
  assign wr_o.waddr = op_i.rd;
  assign wr_o.wdata = alu_res_i;

  // Refused write, reported with the result
  assign blocked_d  = op_valid_i && rd_nonzero && rd_prot;

  // ------------------------------
  // Result registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      res_valid_q <= 1'b0;
      blocked_q   <= 1'b0;
    end
    else
    begin
      res_valid_q <= op_valid_i;
      blocked_q   <= blocked_d;
    end
  end

  // Payload, only loaded on a valid operation
  always_ff @(posedge clk_i)
  begin
    if (op_valid_i)
    begin
      res_data_q <= alu_res_i;
    end
  end

  assign res_valid_o   = res_valid_q;
  assign res_o.data    = res_data_q;
  assign res_o.blocked = blocked_q;

endmodule

/* rtl/rf_exec_top.sv */
// Execute slice top level
// Register file, ALU, issue stage and configuration registers.
// Data width must match rf_pkg::rf_data_t.

`timescale 1ns/1ps

module rf_exec_top #(
  parameter int unsigned ADDR_WIDTH = rf_pkg::ADDR_WIDTH_DEF,
  parameter int unsigned DATA_WIDTH = rf_pkg::DATA_WIDTH_DEF
) (
  input  logic             clk_int,
  input  logic             rst_n,
  // Operation port
  input  logic             op_valid_i,
  input  rf_pkg::rf_op_t   op_i,
  // Configuration port
  input  logic             cfg_valid_i,
  input  rf_pkg::cfg_wr_t  cfg_i,
  // Result port
  output logic             res_valid_o,
  output rf_pkg::rf_res_t  res_o
);

  import rf_pkg::*;

  // Configuration
  rf_mask_t              prot_mask;
  logic                  test_en;

  // Register file ports
  logic [ADDR_WIDTH-1:0] raddr_a;
  logic [ADDR_WIDTH-1:0] raddr_b;
  logic [DATA_WIDTH-1:0] rdata_a;
  logic [DATA_WIDTH-1:0] rdata_b;
  rf_wr_t                wr;

  // ALU ports
  alu_op_t               alu_op;
  rf_data_t              op_a;
  rf_data_t              op_b;
  rf_data_t              alu_res;

  rf_protect_regs u_protect_regs (
    .clk_i       (clk_int),
    .rst_ni      (rst_n),
    .cfg_valid_i (cfg_valid_i),
    .cfg_i       (cfg_i),
    .prot_mask_o (prot_mask),
    .test_en_o   (test_en)
  );

  rf_issue_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_issue_ctrl (
    .clk_i       (clk_int),
    .rst_ni      (rst_n),
    .op_valid_i  (op_valid_i),
    .op_i        (op_i),
    .prot_mask_i (prot_mask),
    .raddr_a_o   (raddr_a),
    .raddr_b_o   (raddr_b),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .alu_op_o    (alu_op),
    .alu_a_o     (op_a),
    .alu_b_o     (op_b),
    .alu_res_i   (alu_res),
    .wr_o        (wr),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

  rf_alu u_alu (
    .op_i  (alu_op),
    .a_i   (op_a),
    .b_i   (op_b),
    .res_o (alu_res)
  );

  rf_latch_regfile #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_regfile (
    .clk_i     (clk_int),
    .rst_ni    (rst_n),
    .test_en_i (test_en),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .wr_i      (wr)
  );

endmodule

/* tests/rf_exec_chk.sv */
// Concurrent rules for the execute slice, bound to rf_exec_top
// Sampled on the rising edge of clk_int, off while reset is low.
// fail_count is read hierarchically by the testbench.

`timescale 1ns/1ps

module rf_exec_chk (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             op_valid_i,
  input rf_pkg::rf_op_t   op_i,
  input rf_pkg::rf_mask_t prot_mask_i,
  input logic             res_valid_i,
  input rf_pkg::rf_res_t  res_i
);

  import rf_pkg::*;

  // Number of failed rules so far
  int unsigned fail_count = 0;

  // ------------------------------
  // Result strobe
  // ------------------------------
  // Exactly one cycle behind the operation strobe
  a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i == $past(op_valid_i))
  else
  begin
    $error("res_valid_o did not follow op_valid_i by one cycle");
    fail_count++;
  end

  // Quiet result port right after reset release
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!res_valid_i && !res_i.blocked))
  else
  begin
    $error("result port active right after reset");
    fail_count++;
  end

  // ------------------------------
  // Register 0 and protection
  // ------------------------------
  // r0 OR r0 must be zero
  a_zero_reg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_valid_i && (op_i.op == ALU_OR) && (op_i.rs1 == '0) && (op_i.rs2 == '0))
    |=> (res_i.data == '0))
  else
  begin
    $error("register 0 did not read as zero");
    fail_count++;
  end

  // Blocked needs a valid op whose rd was masked
  a_blocked_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_i.blocked |-> $past(op_valid_i && prot_mask_i[op_i.rd]))
  else
  begin
    $error("blocked set for an unprotected destination");
    fail_count++;
  end

endmodule

bind rf_exec_top rf_exec_chk u_chk (
  .clk_i       (clk_int),
  .rst_ni      (rst_n),
  .op_valid_i  (op_valid_i),
  .op_i        (op_i),
  .prot_mask_i (prot_mask),
  .res_valid_i (res_valid_o),
  .res_i       (res_o)
);

/* tests/tb_rf_exec.sv */
// Testbench for the execute slice
// The slice has no load path, so seed values enter by forcing the
// ALU result during an add into the target register.
// Results are compared with a shadow register model one cycle later.

`timescale 1ns/1ps

module tb_rf_exec;

  import rf_pkg::*;

  // ------------------------------
  // Run length
  // ------------------------------
  localparam int unsigned ALU_ROUNDS   = 4;
  localparam int unsigned CHAIN_LEN    = 10;
  localparam int unsigned FILL_CYCLES  = 31 * 2 + 31 + 4;
  localparam int unsigned ALU_CYCLES   = ALU_ROUNDS * (2 * 2 + 8 + 1) + 4;
  localparam int unsigned CHAIN_CYCLES = CHAIN_LEN + 4;
  localparam int unsigned MISC_CYCLES  = 4 + 12 + 20 + 4;
  localparam int unsigned STIM_CYCLES  =
    2 * (FILL_CYCLES + ALU_CYCLES + CHAIN_CYCLES) + MISC_CYCLES;
  localparam int unsigned CYCLE_LIMIT  = 2 * STIM_CYCLES + 100;

  logic        clk_int;
  logic        rst_n;
  logic        op_valid;
  rf_op_t      op_req;
  logic        cfg_valid;
  cfg_wr_t     cfg_req;
  logic        res_valid;
  rf_res_t     res;

  // Shadow model and expected results in issue order
  rf_data_t    shadow [32];
  rf_mask_t    mask_m;
  rf_res_t     exp_q [$];
  rf_data_t    lcg_state = 32'd83;
  rf_data_t    seed_value;
  int unsigned cycle_count;
  int unsigned error_count;
  int unsigned tests_run;
  int unsigned tests_failed;

  rf_exec_top dut_i (
    .clk_int     (clk_int),
    .rst_n       (rst_n),
    .op_valid_i  (op_valid),
    .op_i        (op_req),
    .cfg_valid_i (cfg_valid),
    .cfg_i       (cfg_req),
    .res_valid_o (res_valid),
    .res_o       (res)
  );

  // 4 ns period
  always #2 clk_int = ~clk_int;

  always @(posedge clk_int)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Result check, mid-cycle
  // ------------------------------
  always @(negedge clk_int)
  begin
    rf_res_t want;
    if (rst_n && res_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Result at %0t with no operation outstanding", $time);
        error_count++;
      end
      else
      begin
        want = exp_q.pop_front();
        assert (res.data === want.data)
        else
        begin
          $display("Mismatch at %0t: res_o.data expected %h got %h", $time, want.data, res.data);
          error_count++;
        end
        assert (res.blocked === want.blocked)
        else
        begin
          $display("Mismatch at %0t: res_o.blocked expected %b got %b",
                   $time, want.blocked, res.blocked);
          error_count++;
        end
      end
    end
  end

  function automatic rf_data_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference ALU rules
  function automatic rf_data_t model_alu(input alu_op_t sel, input rf_data_t a, input rf_data_t b);
    case (sel)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic int unsigned total_errors();
    return error_count + dut_i.u_chk.fail_count;
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Expected data given, protection and r0 applied to the model
  task automatic drive_op(input alu_op_t sel, input rf_addr_t src_a, input rf_addr_t src_b,
                          input rf_addr_t dst, input rf_data_t data);
    rf_res_t want;
    @(posedge clk_int);
    op_valid <= 1'b1;
    op_req   <= {sel, src_a, src_b, dst};
    want.data    = data;
    want.blocked = (dst != '0) && mask_m[dst];
    if ((dst != '0) && !mask_m[dst])
    begin
      shadow[dst] = data;
    end
    exp_q.push_back(want);
  endtask

  task automatic issue_op(input alu_op_t sel, input rf_addr_t src_a, input rf_addr_t src_b,
                          input rf_addr_t dst);
    drive_op(sel, src_a, src_b, dst, model_alu(sel, shadow[src_a], shadow[src_b]));
  endtask

  task automatic go_idle();
    @(posedge clk_int);
    op_valid <= 1'b0;
  endtask

  // Add r0 + r0 into dst with the ALU result overridden
  task automatic load_reg(input rf_addr_t dst, input rf_data_t value);
    drive_op(ALU_ADD, '0, '0, dst, value);
    @(negedge clk_int);
    seed_value = value;
    force dut_i.alu_res = seed_value;
    @(posedge clk_int);
    op_valid <= 1'b0;
    @(negedge clk_int);
    release dut_i.alu_res;
  endtask

  task automatic write_cfg(input logic sel_bit, input rf_data_t value);
    @(posedge clk_int);
    cfg_valid <= 1'b1;
    cfg_req   <= {sel_bit, value};
    @(posedge clk_int);
    cfg_valid <= 1'b0;
    if (!sel_bit)
    begin
      mask_m = {value[31:1], 1'b0};
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
    begin
      @(posedge clk_int);
    end
  endtask

  // ------------------------------
  // Test bodies
  // ------------------------------
  task automatic fill_and_read(input rf_data_t salt);
    for (int r = 1; r < 32; r++)
    begin
      load_reg(rf_addr_t'(r), (32'(r) * 32'h0101_0101) ^ salt);
    end
    for (int r = 1; r < 32; r++)
    begin
      issue_op(ALU_OR, rf_addr_t'(r), '0, '0);
    end
    go_idle();
    wait_drain();
  endtask

  task automatic alu_sweep();
    repeat (ALU_ROUNDS)
    begin
      load_reg(5'd1, next_random());
      load_reg(5'd2, next_random());
      for (int k = 0; k < 8; k++)
      begin
        issue_op(alu_op_t'(k), 5'd1, 5'd2, rf_addr_t'(3 + k));
      end
      go_idle();
    end
    wait_drain();
  endtask

  // Each op reads the rd of the one before
  task automatic dependent_chain();
    issue_op(ALU_ADD, 5'd1, 5'd2, 5'd11);
    for (int i = 1; i < CHAIN_LEN; i++)
    begin
      issue_op(alu_op_t'(i % 8), rf_addr_t'(10 + i), 5'd2, rf_addr_t'(11 + i));
    end
    go_idle();
    wait_drain();
  endtask

  task automatic report_test(input string name, input int unsigned mark);
    tests_run++;
    if (total_errors() == mark)
    begin
      $display("Test %s passed", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, total_errors() - mark);
    end
  endtask

  initial
  begin
    int unsigned mark;
    clk_int      = 1'b0;
    rst_n        = 1'b0;
    op_valid     = 1'b0;
    op_req       = '0;
    cfg_valid    = 1'b0;
    cfg_req      = '0;
    seed_value   = '0;
    mask_m       = '0;
    cycle_count  = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    shadow[0]    = '0;
    repeat (4) @(posedge clk_int);
    rst_n <= 1'b1;

    mark = total_errors();
    fill_and_read(32'h0);
    report_test("fill_readback", mark);

    mark = total_errors();
    alu_sweep();
    report_test("alu_random", mark);

    mark = total_errors();
    dependent_chain();
    report_test("dependent_chain", mark);

    // r0 writes dropped, forced or computed
    mark = total_errors();
    load_reg('0, 32'hDEAD_BEEF);
    issue_op(ALU_ADD, 5'd1, 5'd2, '0);
    issue_op(ALU_OR, '0, '0, 5'd5);
    issue_op(ALU_OR, '0, '0, '0);
    issue_op(ALU_OR, 5'd5, '0, '0);
    go_idle();
    wait_drain();
    report_test("register_zero", mark);

    // Protect r20 and r21, r22 stays open
    mark = total_errors();
    write_cfg(1'b0, 32'h0030_0001);
    issue_op(ALU_ADD, 5'd1, 5'd2, 5'd20);
    issue_op(ALU_XOR, 5'd1, 5'd2, 5'd21);
    issue_op(ALU_SUB, 5'd1, 5'd2, 5'd22);
    load_reg(5'd20, 32'h1234_5678);
    issue_op(ALU_OR, 5'd20, '0, '0);
    issue_op(ALU_OR, 5'd21, '0, '0);
    issue_op(ALU_OR, 5'd22, '0, '0);
    go_idle();
    wait_drain();
    write_cfg(1'b0, 32'h0);
    report_test("write_protect", mark);

    // Every gate held open
    mark = total_errors();
    write_cfg(1'b1, 32'h1);
    fill_and_read(32'h5A5A_0F0F);
    alu_sweep();
    dependent_chain();
    write_cfg(1'b1, 32'h0);
    report_test("test_enable", mark);

    $display("Tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests_run, tests_failed, error_count, dut_i.u_chk.fail_count);
    if ((tests_failed == 0) && (total_errors() == 0))
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/rf_pkg.sv
rtl/rf_clock_gate.sv
rtl/rf_latch_regfile.sv
rtl/rf_protect_regs.sv
rtl/rf_alu.sv
rtl/rf_issue_ctrl.sv
rtl/rf_exec_top.sv
tests/rf_exec_chk.sv
tests/tb_rf_exec.sv

/* Makefile */
# Verilator build and run for the execute slice testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_rf_exec
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
# Keep running after a failed concurrent assertion so the bench can count it
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
